// ==== list.f ====
periph_pkg.sv
periph_plic_target.sv
periph_plic.sv
periph_timer.sv
periph_reg_demux.sv
periph_credit_port.sv
periph_top.sv
periph_tb_assert.sv
periph_tb.sv

// ==== Bender.yml ====
package:
  name: periph

sources:
  - periph_pkg.sv
  - periph_plic_target.sv
  - periph_plic.sv
  - periph_timer.sv
  - periph_reg_demux.sv
  - periph_credit_port.sv
  - periph_top.sv
  - target: test
    files:
      - periph_tb_assert.sv
      - periph_tb.sv

// ==== periph_tb.sv ====
// Testbench for the peripheral subsystem
// LFSR driven host with credit tracking, register map model and checks
`default_nettype none

module periph_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    localparam int NumRandOps  = 240;
    localparam int NumRounds   = 10;
    localparam int OpsPerRound = 16;
    localparam int TimerOps    = 40;
    localparam int TotalOps    = NumRandOps + NumRounds * OpsPerRound + TimerOps;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req_valid;
    reg_req_t              req;
    logic                  rsp_credit;
    logic [NumExtIrq-1:0]  ext_irq;
    logic                  req_credit;
    logic                  rsp_valid;
    reg_rsp_t              rsp;
    logic [NumTargets-1:0] irq;

    periph_top dut0 (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .req_valid_i  ( req_valid  ),
        .req_i        ( req        ),
        .rsp_credit_i ( rsp_credit ),
        .ext_irq_i    ( ext_irq    ),
        .req_credit_o ( req_credit ),
        .rsp_valid_o  ( rsp_valid  ),
        .rsp_o        ( rsp        ),
        .irq_o        ( irq        )
    );

    always #5 clk = ~clk;

    // ------------------------------
    // Random source and host state
    // ------------------------------
    logic [31:0] lfsr_q = 32'h69411743;
    reg_rsp_t    exp_q[$];
    bit          chk_q[$];
    reg_rsp_t    last_rsp;
    int          req_cred = ReqFifoDepth;
    int          held = 0;
    int          sent = 0;
    int          returned = 0;
    int          grants = 0;
    int          responses = 0;
    int          errors = 0;

    // Register map model
    logic [DataWidth-1:0]  m_count [NumTimers];
    logic [DataWidth-1:0]  m_compare [NumTimers];
    logic [NumTimers-1:0]  m_tenable;
    logic [NumTimers-1:0]  m_tpend;
    prio_t                 m_prio [NumSources];
    logic [NumSources-1:0] m_en [NumTargets];
    prio_t                 m_thr [NumTargets];
    logic [NumSources-1:0] m_pend;
    logic [NumSources-1:0] m_insvc;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // Galois step with taps for x^32 + x^22 + x^2 + x + 1
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic fail_now(input string msg);
        errors++;
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_rsp(input reg_rsp_t got, input reg_rsp_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: rsp_o got %h/%b expected %h/%b", $time,
                     got.rdata, got.error, exp.rdata, exp.error);
            fail_now("response check failed");
        end
    endtask

    task automatic check_irq(input logic [NumTargets-1:0] got,
                             input logic [NumTargets-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: irq_o got %b expected %b", $time, got, exp);
            fail_now("interrupt check failed");
        end
    endtask

    task automatic check_credits(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
            fail_now("credit check failed");
        end
    endtask

    // Highest priority above the threshold wins and the lower index breaks a tie
    function automatic src_id_t best_id(input int t);
        prio_t top;
        top = '0;
        for (int s = 0; s < NumSources; s++) begin
            if (m_pend[s] && m_en[t][s] && (m_prio[s] > m_thr[t]) && (m_prio[s] > top)) begin
                top = m_prio[s];
            end
        end
        for (int s = 0; s < NumSources; s++) begin
            if ((top != '0) && m_pend[s] && m_en[t][s] && (m_prio[s] == top)) begin
                return SrcIdWidth'(s + 1);
            end
        end
        return '0;
    endfunction

    function automatic logic [NumTargets-1:0] model_irq();
        logic [NumTargets-1:0] v;
        for (int t = 0; t < NumTargets; t++) begin
            v[t] = (best_id(t) != '0);
        end
        return v;
    endfunction

    function automatic reg_rsp_t model_access(input logic wr, input logic [15:0] a,
                                              input logic [31:0] wd);
        reg_rsp_t r;
        int       n;
        int       w;
        r = '{rdata: '0, error: 1'b1};
        if (a[15:12] == 4'h0 && a[11:4] < NumTimers) begin
            n = a[11:4];
            r.error = 1'b0;
            case (a[3:2])
                2'd0: if (wr) m_count[n] = wd; else r.rdata = m_count[n];
                2'd1: if (wr) m_compare[n] = wd; else r.rdata = m_compare[n];
                2'd2: if (wr) m_tenable[n] = wd[0]; else r.rdata = 32'(m_tenable[n]);
                default: begin
                    if (wr && wd[0]) m_tpend[n] = 1'b0;
                    if (!wr) r.rdata = 32'(m_tpend[n]);
                end
            endcase
        end else if (a[15:12] == 4'h1) begin
            w = a[7:2];
            r.error = 1'b0;
            if (a[11:8] == 4'h0 && w < NumSources) begin
                if (wr) m_prio[w] = wd[PrioWidth-1:0]; else r.rdata = 32'(m_prio[w]);
            end else if (a[11:8] == 4'h1 && w == 0 && !wr) begin
                r.rdata = 32'(m_pend);
            end else if (a[11:8] == 4'h2 && w < NumTargets) begin
                if (wr) m_en[w] = wd[NumSources-1:0]; else r.rdata = 32'(m_en[w]);
            end else if (a[11:8] == 4'h3 && w < 2 * NumTargets && w % 2 == 0) begin
                if (wr) m_thr[w/2] = wd[PrioWidth-1:0]; else r.rdata = 32'(m_thr[w/2]);
            end else if (a[11:8] == 4'h3 && w < 2 * NumTargets) begin
                if (wr) begin
                    if (wd >= 1 && wd <= NumSources) m_insvc[wd-1] = 1'b0;
                end else begin
                    r.rdata = 32'(best_id(w / 2));
                    if (r.rdata != 0) begin
                        m_pend[r.rdata-1]  = 1'b0;
                        m_insvc[r.rdata-1] = 1'b1;
                    end
                end
            end else begin
                r.error = 1'b1;
            end
        end
        return r;
    endfunction

    // ------------------------------
    // Host driver
    // ------------------------------
    task automatic send_op(input logic wr, input logic [15:0] a, input logic [31:0] wd,
                           input bit chk, output reg_rsp_t exp);
        exp = model_access(wr, a, wd);
        @(posedge clk);
        #1;
        while (req_cred == 0) begin
            @(posedge clk);
            #1;
        end
        exp_q.push_back(exp);
        chk_q.push_back(chk);
        req_valid = 1'b1;
        req       = '{write: wr, addr: a, wdata: wd};
        req_cred--;
        sent++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // Waits for all responses, then lets the gateways settle
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #1;
        m_pend = m_pend | ({ext_irq, m_tpend} & ~m_insvc);
    endtask

    task automatic drive_ext(input logic [NumExtIrq-1:0] v);
        drain();
        @(posedge clk);
        #1;
        ext_irq = v;
        drain();
    endtask

    task automatic random_legal_op();
        reg_rsp_t    e;
        logic        wr;
        logic [1:0]  k;
        logic [31:0] wd;
        int          i;
        wr = take_bits(1);
        wd = take_bits(32);
        k  = take_bits(2) % 3;
        i  = take_bits(1);
        if (take_bits(1)) begin
            // Timer count, compare or control with enable kept off
            if (k == 2) wd[0] = 1'b0;
            send_op(wr, {4'h0, 8'(i), k, 2'(take_bits(2))}, wd, 1'b1, e);
        end else if (k == 0) begin
            send_op(wr, {4'h1, 4'h0, 6'(take_bits(2)), 2'b00}, wd, 1'b1, e);
        end else begin
            send_op(wr, {4'h1, (k == 1) ? 4'h2 : 4'h3, 6'((k == 1) ? i : 2 * i), 2'b00},
                    wd, 1'b1, e);
        end
    endtask

    task automatic random_bad_op();
        reg_rsp_t   e;
        logic [3:0] region;
        case (take_bits(2))
            2'd0: begin
                region = take_bits(4);
                if (region < 2) region = region + 4'd2;
                send_op(take_bits(1), {region, 12'(take_bits(12))}, take_bits(32), 1'b1, e);
            end
            2'd1: send_op(take_bits(1), {4'h0, 8'(2 + take_bits(7)), 4'(take_bits(4))},
                          take_bits(32), 1'b1, e);
            2'd2: send_op(take_bits(1), {4'h1, 4'(4 + take_bits(3)), 8'(take_bits(8))},
                          take_bits(32), 1'b1, e);
            default: send_op(1'b1, 16'h1100, take_bits(32), 1'b1, e);
        endcase
    endtask

    // ------------------------------
    // Credit grants and response monitor
    // ------------------------------
    initial begin
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            rsp_credit = (held < RspCreditMax) && take_bits(1);
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (rsp_credit) begin
                held++;
                grants++;
            end
            if (req_credit) begin
                held--;
                req_cred++;
                returned++;
            end
            if (rsp_valid) begin
                responses++;
                if (responses > grants) fail_now("more responses than credits granted");
                if (exp_q.size() == 0) fail_now("response with no request outstanding");
                last_rsp = rsp;
                if (chk_q.pop_front()) check_rsp(rsp, exp_q.pop_front());
                else void'(exp_q.pop_front());
            end
            if (held < 0 || held > RspCreditMax) fail_now("response credit count out of range");
            if (dut0.i_credit_port.i_credit_assert.fail_count != 0) begin
                fail_now("credit protocol assertion failed");
            end
        end
    end

    initial begin
        repeat (TotalOps * 50) @(posedge clk);
        fail_now("watchdog timeout, the run did not complete");
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        reg_rsp_t   e1;
        reg_rsp_t   e2;
        reg_rsp_t   e;
        bit         seen;
        int         t;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_credit = 1'b0;
        ext_irq    = '0;
        m_tenable  = '0;
        m_tpend    = '0;
        m_pend     = '0;
        m_insvc    = '0;
        for (int n = 0; n < NumTimers; n++) begin
            m_count[n]   = '0;
            m_compare[n] = '0;
        end
        for (int s = 0; s < NumSources; s++) m_prio[s] = '0;
        for (int i = 0; i < NumTargets; i++) begin
            m_en[i]  = '0;
            m_thr[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_irq(irq, '0);

        // Register read/write mixed with unmapped accesses
        for (int i = 0; i < NumRandOps; i++) begin
            if (take_bits(2) == 0) random_bad_op();
            else random_legal_op();
        end
        drain();

        // Interrupt routing and claim/complete
        for (int r = 0; r < NumRounds; r++) begin
            drive_ext(take_bits(NumExtIrq));
            for (int s = 0; s < NumSources; s++) begin
                send_op(1'b1, {4'h1, 4'h0, 6'(s), 2'b00}, take_bits(32), 1'b1, e);
            end
            for (int i = 0; i < NumTargets; i++) begin
                send_op(1'b1, {4'h1, 4'h2, 6'(i), 2'b00}, take_bits(32), 1'b1, e);
                send_op(1'b1, {4'h1, 4'h3, 6'(2 * i), 2'b00}, take_bits(2), 1'b1, e);
            end
            drain();
            check_irq(irq, model_irq());
            t = take_bits(1);
            send_op(1'b0, {4'h1, 4'h3, 6'(2 * t + 1), 2'b00}, '0, 1'b1, e1);
            send_op(1'b0, {4'h1, 4'h3, 6'(2 * t + 1), 2'b00}, '0, 1'b1, e2);
            drain();
            check_irq(irq, model_irq());
            if (e1.rdata != 0) send_op(1'b1, {4'h1, 4'h3, 6'(2 * t + 1), 2'b00},
                                       e1.rdata, 1'b1, e);
            if (e2.rdata != 0) send_op(1'b1, {4'h1, 4'h3, 6'(2 * t + 1), 2'b00},
                                       e2.rdata, 1'b1, e);
            drain();
            // Sources still high come back as pending
            send_op(1'b0, 16'h1100, '0, 1'b1, e);
            drain();
            check_irq(irq, model_irq());
        end

        // Timer 0 raising source 1 on target 0
        drive_ext('0);
        send_op(1'b1, 16'h1000, 32'd7, 1'b1, e);
        send_op(1'b1, 16'h1200, 32'h1, 1'b1, e);
        send_op(1'b1, 16'h1204, 32'h0, 1'b1, e);
        send_op(1'b1, 16'h1300, 32'h0, 1'b1, e);
        send_op(1'b1, 16'h0004, 32'(3 + take_bits(3)), 1'b1, e);
        send_op(1'b1, 16'h0000, 32'h0, 1'b1, e);
        send_op(1'b1, 16'h0008, 32'h1, 1'b1, e);
        seen = 1'b0;
        for (int p = 0; p < 20 && !seen; p++) begin
            send_op(1'b0, 16'h000C, '0, 1'b0, e);
            drain();
            seen = last_rsp.rdata[0] && !last_rsp.error;
        end
        if (!seen) fail_now("timer 0 pending never set");
        m_tpend[0] = 1'b1;
        drain();
        check_irq(irq, model_irq());
        send_op(1'b0, 16'h1304, '0, 1'b1, e);
        send_op(1'b1, 16'h0008, 32'h0, 1'b1, e);
        send_op(1'b1, 16'h000C, 32'h1, 1'b1, e);
        send_op(1'b1, 16'h1304, 32'h1, 1'b1, e);
        drain();
        check_irq(irq, model_irq());
        check_irq(irq, '0);

        check_credits("req_credit_o pulses", returned, sent);
        check_credits("responses", responses, sent);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== periph_tb_assert.sv ====
// Credit protocol checks for the register port
// Bound into periph_credit_port
`default_nettype none

module periph_tb_assert (
    input wire logic                                     clk_i,
    input wire logic                                     rst_n_i,
    input wire logic                                     req_valid_i,
    input wire logic                                     rsp_credit_i,
    input wire logic                                     req_credit_o,
    input wire logic [$clog2(periph_pkg::ReqFifoDepth):0] fill_i,
    input wire logic [$clog2(periph_pkg::RspCreditMax):0] credit_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import periph_pkg::*;

    // Read by the testbench to end the run
    int unsigned fail_count = 0;

    // Host must hold a request credit, so the FIFO is never full here
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> (fill_i != ReqFifoDepth))
        else begin
            $error("request arrived while the request FIFO was full");
            fail_count++;
        end

    no_grant_when_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_credit_i |-> (credit_i != RspCreditMax))
        else begin
            $error("response credit granted above the limit");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk_i)
        (!rst_n_i && $past(!rst_n_i)) |-> !req_credit_o)
        else begin
            $error("req_credit_o high during reset");
            fail_count++;
        end

endmodule

bind periph_credit_port periph_tb_assert i_credit_assert (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .req_valid_i  ( req_valid_i  ),
    .rsp_credit_i ( rsp_credit_i ),
    .req_credit_o ( req_credit_o ),
    .fill_i       ( fill_q       ),
    .credit_i     ( credit_q     )
);

`default_nettype wire

// ==== periph_top.sv ====
// Peripheral subsystem top
// Credit port, address decoder, interval timers and PLIC
`default_nettype none

module periph_top (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              req_valid_i,
    input  periph_pkg::reg_req_t              req_i,
    input  logic                              rsp_credit_i,
    input  logic [periph_pkg::NumExtIrq-1:0]  ext_irq_i,
    output logic                              req_credit_o,
    output logic                              rsp_valid_o,
    output periph_pkg::reg_rsp_t              rsp_o,
    output logic [periph_pkg::NumTargets-1:0] irq_o
);
    import periph_pkg::*;

    logic                  issue_valid;
    reg_req_t              issue_req;
    reg_req_t              slv_req;
    logic                  timer_sel;
    logic                  plic_sel;
    reg_rsp_t              timer_rsp;
    reg_rsp_t              plic_rsp;
    logic [NumTimers-1:0]  timer_irq;
    logic [NumSources-1:0] irq_sources;

    // Timers take the low source indices, external lines follow
    assign irq_sources = {ext_irq_i, timer_irq};

    // ------------------------------
    // Host port and decode
    // ------------------------------
    periph_credit_port i_credit_port (
        .clk_i         ( clk_i        ),
        .rst_n_i       ( rst_n_i      ),
        .req_valid_i   ( req_valid_i  ),
        .req_i         ( req_i        ),
        .rsp_credit_i  ( rsp_credit_i ),
        .req_credit_o  ( req_credit_o ),
        .issue_valid_o ( issue_valid  ),
        .issue_req_o   ( issue_req    )
    );

    periph_reg_demux i_reg_demux (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .issue_valid_i ( issue_valid ),
        .issue_req_i   ( issue_req   ),
        .timer_sel_o   ( timer_sel   ),
        .plic_sel_o    ( plic_sel    ),
        .slv_req_o     ( slv_req     ),
        .timer_rsp_i   ( timer_rsp   ),
        .plic_rsp_i    ( plic_rsp    ),
        .rsp_valid_o   ( rsp_valid_o ),
        .rsp_o         ( rsp_o       )
    );

    // ------------------------------
    // Timers and PLIC
    // ------------------------------
    periph_timer i_timer (
        .clk_i   ( clk_i     ),
        .rst_n_i ( rst_n_i   ),
        .sel_i   ( timer_sel ),
        .req_i   ( slv_req   ),
        .rsp_o   ( timer_rsp ),
        .irq_o   ( timer_irq )
    );

    periph_plic i_plic (
        .clk_i   ( clk_i       ),
        .rst_n_i ( rst_n_i     ),
        .sel_i   ( plic_sel    ),
        .req_i   ( slv_req     ),
        .rsp_o   ( plic_rsp    ),
        .src_i   ( irq_sources ),
        .irq_o   ( irq_o       )
    );

endmodule

`default_nettype wire

// ==== periph_credit_port.sv ====
// Credit-based register port
// Buffers host requests and issues them while response credits are held
`default_nettype none

module periph_credit_port (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  periph_pkg::reg_req_t req_i,
    input  logic                 rsp_credit_i,
    output logic                 req_credit_o,
    output logic                 issue_valid_o,
    output periph_pkg::reg_req_t issue_req_o
);
    import periph_pkg::*;

    reg_req_t                          fifo_q [ReqFifoDepth];
    logic [$clog2(ReqFifoDepth)-1:0]   wr_ptr_q;
    logic [$clog2(ReqFifoDepth)-1:0]   rd_ptr_q;
    logic [$clog2(ReqFifoDepth):0]     fill_q;
    logic [$clog2(RspCreditMax):0]     credit_q;
    logic                              push;
    logic                              pop;

    // Host only sends while it holds a credit, so full is a protocol error
    assign push = req_valid_i && (fill_q != ReqFifoDepth);
    assign pop  = (fill_q != '0) && (credit_q != '0);

    // Payload storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            fifo_q[wr_ptr_q] <= req_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            credit_q <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({push, pop})
                2'b10:   fill_q <= fill_q + 1'b1;
                2'b01:   fill_q <= fill_q - 1'b1;
                default: fill_q <= fill_q;
            endcase
            // One credit per grant, one consumed per issued request
            case ({rsp_credit_i, pop})
                2'b10:   credit_q <= credit_q + 1'b1;
                2'b01:   credit_q <= credit_q - 1'b1;
                default: credit_q <= credit_q;
            endcase
        end
    end

    assign issue_valid_o = pop;
    assign issue_req_o   = fifo_q[rd_ptr_q];
    assign req_credit_o  = pop;

endmodule

`default_nettype wire

// ==== periph_reg_demux.sv ====
// Register address decoder
// Routes issued requests to the timer or PLIC and registers the response
`default_nettype none

module periph_reg_demux (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 issue_valid_i,
    input  periph_pkg::reg_req_t issue_req_i,
    output logic                 timer_sel_o,
    output logic                 plic_sel_o,
    output periph_pkg::reg_req_t slv_req_o,
    input  periph_pkg::reg_rsp_t timer_rsp_i,
    input  periph_pkg::reg_rsp_t plic_rsp_i,
    output logic                 rsp_valid_o,
    output periph_pkg::reg_rsp_t rsp_o
);
    import periph_pkg::*;

    logic [3:0] region;
    logic       unmapped;
    reg_rsp_t   rsp_d;

    // ------------------------------
    // Region decode
    // ------------------------------
    assign region = issue_req_i.addr[AddrWidth-1:AddrWidth-4];

    assign timer_sel_o = issue_valid_i && (region == RegionTimer);
    assign plic_sel_o  = issue_valid_i && (region == RegionPlic);
    assign unmapped    = (region != RegionTimer) && (region != RegionPlic);

    // Both blocks see the same request, only the selected one acts on it
    assign slv_req_o = issue_req_i;

    always_comb begin
        rsp_d = timer_rsp_i;
        if (region == RegionPlic) begin
            rsp_d = plic_rsp_i;
        end
        // Unmapped space answers with an error and no data
        if (unmapped) begin
            rsp_d.rdata = '0;
            rsp_d.error = 1'b1;
        end
    end

    // ------------------------------
    // Response register
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
            rsp_o       <= '0;
        end else begin
            rsp_valid_o <= issue_valid_i;
            if (issue_valid_i) begin
                rsp_o <= rsp_d;
            end
        end
    end

endmodule

`default_nettype wire

// ==== periph_timer.sv ====
// Interval timer block
// Each timer counts up to its compare value, wraps and flags pending
`default_nettype none

module periph_timer (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             sel_i,
    input  periph_pkg::reg_req_t             req_i,
    output periph_pkg::reg_rsp_t             rsp_o,
    output logic [periph_pkg::NumTimers-1:0] irq_o
);
    import periph_pkg::*;

    logic [NumTimers-1:0][DataWidth-1:0] count_q;
    logic [NumTimers-1:0][DataWidth-1:0] compare_q;
    logic [NumTimers-1:0]                enable_q;
    logic [NumTimers-1:0]                pending_q;

    logic [NumTimers-1:0] hit;
    logic [NumTimers-1:0] count_wr;
    logic [NumTimers-1:0] wrap;
    logic [1:0]           reg_idx;
    logic                 wr;

    // Timer n at n*0x10, register select in bits 3:2
    assign reg_idx = req_i.addr[3:2];
    assign wr      = sel_i && req_i.write;

    always_comb begin
        rsp_o = '0;
        for (int n = 0; n < NumTimers; n++) begin
            hit[n]      = (req_i.addr[11:4] == 8'(n));
            count_wr[n] = wr && hit[n] && (reg_idx == 2'd0);
            // A count write wins over the compare match
            wrap[n]     = enable_q[n] && (count_q[n] == compare_q[n]) && !count_wr[n];
            if (hit[n] && !req_i.write) begin
                case (reg_idx)
                    2'd0:    rsp_o.rdata = count_q[n];
                    2'd1:    rsp_o.rdata = compare_q[n];
                    2'd2:    rsp_o.rdata = DataWidth'(enable_q[n]);
                    default: rsp_o.rdata = DataWidth'(pending_q[n]);
                endcase
            end
        end
        rsp_o.error = ~|hit;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            compare_q <= '0;
            enable_q  <= '0;
            pending_q <= '0;
        end else begin
            for (int n = 0; n < NumTimers; n++) begin
                if (count_wr[n]) count_q[n] <= req_i.wdata;
                else if (wrap[n]) count_q[n] <= '0;
                else if (enable_q[n]) count_q[n] <= count_q[n] + 1'b1;

                if (wr && hit[n] && (reg_idx == 2'd1)) compare_q[n] <= req_i.wdata;
                if (wr && hit[n] && (reg_idx == 2'd2)) enable_q[n] <= req_i.wdata[0];

                // New match beats a write-one-to-clear
                if (wrap[n]) begin
                    pending_q[n] <= 1'b1;
                end else if (wr && hit[n] && (reg_idx == 2'd3) && req_i.wdata[0]) begin
                    pending_q[n] <= 1'b0;
                end
            end
        end
    end

    assign irq_o = pending_q;

endmodule

`default_nettype wire

// ==== periph_plic.sv ====
// Platform-level interrupt controller
// Level gateways, priority/enable/threshold registers and claim/complete
`default_nettype none

module periph_plic (
    input  logic                              clk_i,
    input  logic                              rst_n_i,
    input  logic                              sel_i,
    input  periph_pkg::reg_req_t              req_i,
    output periph_pkg::reg_rsp_t              rsp_o,
    input  logic [periph_pkg::NumSources-1:0] src_i,
    output logic [periph_pkg::NumTargets-1:0] irq_o
);
    import periph_pkg::*;

    prio_t [NumSources-1:0]                  prio_q;
    logic  [NumTargets-1:0][NumSources-1:0]  enable_q;
    prio_t [NumTargets-1:0]                  threshold_q;
    logic  [NumSources-1:0]                  pending_q;
    logic  [NumSources-1:0]                  in_service_q;
    src_id_t [NumTargets-1:0]                best_id;

    logic [3:0]            page;
    logic [5:0]            word;
    logic [NumSources-1:0] prio_hit;
    logic                  pend_hit;
    logic [NumTargets-1:0] enable_hit;
    logic [NumTargets-1:0] thresh_hit;
    logic [NumTargets-1:0] claim_hit;
    logic [NumSources-1:0] claim_mask;
    logic [NumSources-1:0] complete_mask;
    logic                  wr;
    logic                  rd;

    assign page = req_i.addr[11:8];
    assign word = req_i.addr[7:2];
    assign wr   = sel_i && req_i.write;
    assign rd   = sel_i && !req_i.write;

    // ------------------------------
    // Offset decode and read data
    // ------------------------------
    always_comb begin
        rsp_o    = '0;
        pend_hit = (page == 4'h1) && (word == '0);
        for (int s = 0; s < NumSources; s++) begin
            prio_hit[s] = (page == 4'h0) && (word == 6'(s));
            if (prio_hit[s] && !req_i.write) rsp_o.rdata = DataWidth'(prio_q[s]);
        end
        for (int t = 0; t < NumTargets; t++) begin
            enable_hit[t] = (page == 4'h2) && (word == 6'(t));
            // Threshold and claim interleave at 8 byte stride
            thresh_hit[t] = (page == 4'h3) && (word == 6'(2 * t));
            claim_hit[t]  = (page == 4'h3) && (word == 6'(2 * t + 1));
            if (!req_i.write) begin
                if (enable_hit[t]) rsp_o.rdata = DataWidth'(enable_q[t]);
                if (thresh_hit[t]) rsp_o.rdata = DataWidth'(threshold_q[t]);
                if (claim_hit[t])  rsp_o.rdata = DataWidth'(best_id[t]);
            end
        end
        if (pend_hit && !req_i.write) rsp_o.rdata = DataWidth'(pending_q);
        // Pending bits are read-only
        rsp_o.error = !(|prio_hit || |enable_hit || |thresh_hit || |claim_hit ||
                        (pend_hit && !req_i.write));
    end

    // Claim and complete masks per source
    always_comb begin
        claim_mask    = '0;
        complete_mask = '0;
        for (int t = 0; t < NumTargets; t++) begin
            for (int s = 0; s < NumSources; s++) begin
                if (rd && claim_hit[t] && (best_id[t] == SrcIdWidth'(s + 1))) begin
                    claim_mask[s] = 1'b1;
                end
                if (wr && claim_hit[t] && (req_i.wdata == DataWidth'(s + 1))) begin
                    complete_mask[s] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            prio_q       <= '0;
            enable_q     <= '0;
            threshold_q  <= '0;
            pending_q    <= '0;
            in_service_q <= '0;
        end else begin
            for (int s = 0; s < NumSources; s++) begin
                if (wr && prio_hit[s]) prio_q[s] <= req_i.wdata[PrioWidth-1:0];
            end
            for (int t = 0; t < NumTargets; t++) begin
                if (wr && enable_hit[t]) enable_q[t] <= req_i.wdata[NumSources-1:0];
                if (wr && thresh_hit[t]) threshold_q[t] <= req_i.wdata[PrioWidth-1:0];
            end
            // Level gateway, blocked while the source is in service
            pending_q    <= (pending_q | (src_i & ~in_service_q)) & ~claim_mask;
            in_service_q <= (in_service_q | claim_mask) & ~complete_mask;
        end
    end

    // ------------------------------
    // Per-target selection
    // ------------------------------
    for (genvar t = 0; t < NumTargets; t++) begin : gen_target
        periph_plic_target i_target (
            .pending_i   ( pending_q      ),
            .enable_i    ( enable_q[t]    ),
            .prio_i      ( prio_q         ),
            .threshold_i ( threshold_q[t] ),
            .best_id_o   ( best_id[t]     ),
            .eip_o       ( irq_o[t]       )
        );
    end

endmodule

`default_nettype wire

// ==== periph_plic_target.sv ====
// PLIC target selection
// Picks the highest-priority pending and enabled source above threshold
`default_nettype none

module periph_plic_target (
    input  logic [periph_pkg::NumSources-1:0]              pending_i,
    input  logic [periph_pkg::NumSources-1:0]              enable_i,
    input  periph_pkg::prio_t [periph_pkg::NumSources-1:0] prio_i,
    input  periph_pkg::prio_t                              threshold_i,
    output periph_pkg::src_id_t                            best_id_o,
    output logic                                           eip_o
);
    import periph_pkg::*;

    logic [NumSources-1:0] eligible;
    prio_t                 best_prio;

    assign eligible = pending_i & enable_i;

    // Start the bar at the threshold so only strictly higher priorities qualify.
    // A strict compare keeps ties on the lower index.
    always_comb begin
        best_prio = threshold_i;
        best_id_o = '0;
        for (int s = 0; s < NumSources; s++) begin
            if (eligible[s] && (prio_i[s] > best_prio)) begin
                best_prio = prio_i[s];
                best_id_o = SrcIdWidth'(s + 1);
            end
        end
    end

    assign eip_o = (best_id_o != '0);

endmodule

`default_nettype wire

// ==== periph_pkg.sv ====
// Peripheral subsystem shared definitions
// Bus widths, region codes, PLIC sizing and register bus structs
`default_nettype none

package periph_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int unsigned AddrWidth = 16;
    localparam int unsigned DataWidth = 32;

    // Region codes in address bits 15:12
    localparam logic [3:0] RegionTimer = 4'h0;
    localparam logic [3:0] RegionPlic  = 4'h1;

    // ------------------------------
    // Timer and PLIC sizing
    // ------------------------------
    localparam int unsigned NumTimers  = 2;
    localparam int unsigned NumExtIrq  = 2;
    localparam int unsigned NumSources = NumTimers + NumExtIrq;
    localparam int unsigned NumTargets = 2;
    localparam int unsigned PrioWidth  = 3;
    localparam int unsigned SrcIdWidth = 3;

    // Flow control
    localparam int unsigned ReqFifoDepth = 2;
    localparam int unsigned RspCreditMax = 2;

    typedef logic [PrioWidth-1:0]  prio_t;
    // Id 0 means no source, source s has id s+1
    typedef logic [SrcIdWidth-1:0] src_id_t;

    typedef struct packed {
        logic                 write;
        logic [AddrWidth-1:0] addr;
        logic [DataWidth-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [DataWidth-1:0] rdata;
        logic                 error;
    } reg_rsp_t;

endpackage

`default_nettype wire
